//--- source/cpu_pkg.sv
package cpu_pkg;

	localparam int word_w = 32;
	localparam int reg_addr_w = 5;
	localparam int imem_depth_log2 = 6;
	localparam int dmem_depth_log2 = 6;

	// primary opcodes, instr[31:26]
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j = 6'h02;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_addi = 6'h08;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_sw = 6'h2b;

	// r-type function codes, instr[5:0]
	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;

	// alu_add is zero so a cleared bundle is still a legal alu selection
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or = 3'd3,
		alu_slt = 3'd4,
		alu_sll = 3'd5
	} alu_op_t;

	typedef struct packed {
		logic regwrite;
		logic memtoreg;
		logic memread;
		logic memwrite;
		logic isbranch;
		logic isjump;
		logic alusrc;
		logic regdst;
		alu_op_t alu;
	} ctrl_t;

	typedef struct packed {
		logic valid;
		logic [word_w-1:0] pc_next;
		logic [word_w-1:0] instr;
	} if_id_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		logic [word_w-1:0] pc_next;
		logic [word_w-1:0] data_rs;
		logic [word_w-1:0] data_rt;
		logic [word_w-1:0] imm;
		logic [word_w-1:0] pc_jump;
		logic [reg_addr_w-1:0] rt;
		logic [reg_addr_w-1:0] rd;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		logic [word_w-1:0] pc_branch;
		logic zero;
		logic [word_w-1:0] alu_result;
		logic [word_w-1:0] data_rt;
		logic [reg_addr_w-1:0] wreg;
	} ex_mem_t;

	typedef struct packed {
		logic valid;
		logic regwrite;
		logic memtoreg;
		logic [word_w-1:0] memout;
		logic [word_w-1:0] alu_result;
		logic [reg_addr_w-1:0] wreg;
	} mem_wb_t;

endpackage

//--- source/dmem_if.sv
`timescale 1ns/1ps

interface dmem_if;

	logic [cpu_pkg::word_w-1:0] addr;
	logic [cpu_pkg::word_w-1:0] wdata;
	logic read;
	logic write;
	// memory answers within the same cycle
	logic [cpu_pkg::word_w-1:0] rdata;

	modport core (
		output addr, wdata, read, write,
		input rdata
	);

	modport mem (
		input addr, wdata, read, write,
		output rdata
	);

endinterface

//--- source/control.sv
`timescale 1ns/1ps

module control (
	input logic [5:0] opcode,
	input logic [5:0] funct,
	output cpu_pkg::ctrl_t ctrl
);

	always_comb begin
		// anything not listed below becomes a bubble
		ctrl = '0;
		case (opcode)
			cpu_pkg::op_rtype: begin
				ctrl.regwrite = 1'b1;
				ctrl.regdst = 1'b1;
				case (funct)
					cpu_pkg::fn_add: ctrl.alu = cpu_pkg::alu_add;
					cpu_pkg::fn_sub: ctrl.alu = cpu_pkg::alu_sub;
					cpu_pkg::fn_and: ctrl.alu = cpu_pkg::alu_and;
					cpu_pkg::fn_or: ctrl.alu = cpu_pkg::alu_or;
					cpu_pkg::fn_slt: ctrl.alu = cpu_pkg::alu_slt;
					cpu_pkg::fn_sll: ctrl.alu = cpu_pkg::alu_sll;
					default: ctrl = '0;
				endcase
			end
			cpu_pkg::op_addi: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.alu = cpu_pkg::alu_add;
			end
			cpu_pkg::op_lw: begin
				ctrl.regwrite = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.memread = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.alu = cpu_pkg::alu_add;
			end
			cpu_pkg::op_sw: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.alu = cpu_pkg::alu_add;
			end
			cpu_pkg::op_beq: begin
				// equal operands leave a zero difference
				ctrl.isbranch = 1'b1;
				ctrl.alu = cpu_pkg::alu_sub;
			end
			cpu_pkg::op_j: begin
				ctrl.isjump = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
	input cpu_pkg::alu_op_t op,
	input logic [cpu_pkg::word_w-1:0] s,
	input logic [cpu_pkg::word_w-1:0] t,
	input logic [4:0] shamt,
	output logic [cpu_pkg::word_w-1:0] result,
	output logic zero
);

	always_comb begin
		case (op)
			cpu_pkg::alu_add: begin
				result = s + t;
			end
			cpu_pkg::alu_sub: begin
				result = s - t;
			end
			cpu_pkg::alu_and: begin
				result = s & t;
			end
			cpu_pkg::alu_or: begin
				result = s | t;
			end
			cpu_pkg::alu_slt: begin
				// signed compare, result is 0 or 1
				result = {{(cpu_pkg::word_w-1){1'b0}}, $signed(s) < $signed(t)};
			end
			cpu_pkg::alu_sll: begin
				// sll shifts rt, rs is ignored
				result = t << shamt;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- source/regfile.sv
`timescale 1ns/1ps

module regfile (
	input logic clk,
	input logic rst_n,
	input logic [cpu_pkg::reg_addr_w-1:0] rreg1,
	input logic [cpu_pkg::reg_addr_w-1:0] rreg2,
	output logic [cpu_pkg::word_w-1:0] rdata1,
	output logic [cpu_pkg::word_w-1:0] rdata2,
	input logic we,
	input logic [cpu_pkg::reg_addr_w-1:0] wreg,
	input logic [cpu_pkg::word_w-1:0] wdata,
	input logic [cpu_pkg::reg_addr_w-1:0] dbg_reg,
	output logic [cpu_pkg::word_w-1:0] dbg_data
);

	logic [cpu_pkg::word_w-1:0] regs [2**cpu_pkg::reg_addr_w];
	logic wr_ok;

	// r0 is never written, so it keeps its reset value of zero
	assign wr_ok = we && (wreg != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			regs <= '{default: '0};
		end else if (wr_ok) begin
			regs[wreg] <= wdata;
		end
	end

	// write-through so decode sees the value retiring this cycle
	assign rdata1 = (wr_ok && wreg == rreg1) ? wdata : regs[rreg1];
	assign rdata2 = (wr_ok && wreg == rreg2) ? wdata : regs[rreg2];
	assign dbg_data = regs[dbg_reg];

endmodule

//--- source/instr_mem.sv
`timescale 1ns/1ps

module instr_mem (
	input logic clk,
	input logic [cpu_pkg::word_w-1:0] pc,
	output logic [cpu_pkg::word_w-1:0] instr,
	input logic load_we,
	input logic [cpu_pkg::imem_depth_log2-1:0] load_addr,
	input logic [cpu_pkg::word_w-1:0] load_data
);

	logic [cpu_pkg::word_w-1:0] mem [2**cpu_pkg::imem_depth_log2];

	// program loading only, the core never writes here
	always_ff @(posedge clk) begin
		if (load_we) begin
			mem[load_addr] <= load_data;
		end
	end

	// byte address to word index, upper pc bits wrap
	assign instr = mem[pc[cpu_pkg::imem_depth_log2+1:2]];

endmodule

//--- source/data_mem.sv
`timescale 1ns/1ps

module data_mem (
	input logic clk,
	dmem_if.mem bus
);

	logic [cpu_pkg::word_w-1:0] mem [2**cpu_pkg::dmem_depth_log2];
	logic [cpu_pkg::dmem_depth_log2-1:0] idx;

	// word index from the byte address
	assign idx = bus.addr[cpu_pkg::dmem_depth_log2+1:2];

	always_ff @(posedge clk) begin
		if (bus.write) begin
			mem[idx] <= bus.wdata;
		end
	end

	// idle reads return zero
	assign bus.rdata = bus.read ? mem[idx] : '0;

endmodule

//--- source/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
	input logic clk,
	input logic rst_n,
	input logic run,
	output logic [cpu_pkg::word_w-1:0] pc,
	input logic [cpu_pkg::word_w-1:0] instr,
	output logic [5:0] opcode,
	output logic [5:0] funct,
	input cpu_pkg::ctrl_t ctrl,
	output logic [cpu_pkg::reg_addr_w-1:0] rreg1,
	output logic [cpu_pkg::reg_addr_w-1:0] rreg2,
	input logic [cpu_pkg::word_w-1:0] rdata1,
	input logic [cpu_pkg::word_w-1:0] rdata2,
	output cpu_pkg::alu_op_t alu_op,
	output logic [cpu_pkg::word_w-1:0] alu_s,
	output logic [cpu_pkg::word_w-1:0] alu_t,
	output logic [4:0] shamt,
	input logic [cpu_pkg::word_w-1:0] alu_result,
	input logic alu_zero,
	dmem_if.core dmem,
	output logic wb_we,
	output logic [cpu_pkg::reg_addr_w-1:0] wb_reg,
	output logic [cpu_pkg::word_w-1:0] wb_data
);

	cpu_pkg::if_id_t if_id;
	cpu_pkg::id_ex_t id_ex;
	cpu_pkg::ex_mem_t ex_mem;
	cpu_pkg::mem_wb_t mem_wb;

	logic [cpu_pkg::word_w-1:0] pc_plus4;
	logic [cpu_pkg::word_w-1:0] pc_next;
	logic [cpu_pkg::word_w-1:0] id_imm;
	logic [cpu_pkg::word_w-1:0] id_pc_jump;
	logic [cpu_pkg::word_w-1:0] ex_pc_branch;
	logic [cpu_pkg::reg_addr_w-1:0] ex_wreg;
	logic jump_taken;
	logic branch_taken;

	// fetch
	assign pc_plus4 = pc + 32'd4;

	// j resolves in execute, beq in memory; the older branch wins
	assign jump_taken = id_ex.valid && id_ex.ctrl.isjump;
	assign branch_taken = ex_mem.valid && ex_mem.ctrl.isbranch && ex_mem.zero;

	always_comb begin
		if (branch_taken) begin
			pc_next = ex_mem.pc_branch;
		end else if (jump_taken) begin
			pc_next = id_ex.pc_jump;
		end else begin
			pc_next = pc_plus4;
		end
	end

	// decode
	assign opcode = if_id.instr[31:26];
	assign funct = if_id.instr[5:0];
	assign rreg1 = if_id.instr[25:21];
	assign rreg2 = if_id.instr[20:16];
	assign id_imm = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
	assign id_pc_jump = {if_id.pc_next[31:28], if_id.instr[25:0], 2'b00};

	// execute
	assign alu_op = id_ex.ctrl.alu;
	assign alu_s = id_ex.data_rs;
	assign alu_t = id_ex.ctrl.alusrc ? id_ex.imm : id_ex.data_rt;
	assign shamt = id_ex.imm[10:6];
	assign ex_wreg = id_ex.ctrl.regdst ? id_ex.rd : id_ex.rt;
	assign ex_pc_branch = id_ex.pc_next + (id_ex.imm << 2);

	// memory
	assign dmem.addr = ex_mem.alu_result;
	assign dmem.wdata = ex_mem.data_rt;
	assign dmem.read = ex_mem.valid && ex_mem.ctrl.memread;
	assign dmem.write = ex_mem.valid && ex_mem.ctrl.memwrite;

	// write-back
	assign wb_we = mem_wb.valid && mem_wb.regwrite;
	assign wb_reg = mem_wb.wreg;
	assign wb_data = mem_wb.memtoreg ? mem_wb.memout : mem_wb.alu_result;

	always_ff @(posedge clk) begin
		if (!rst_n || !run) begin
			// hold at zero and drain the pipeline
			pc <= '0;
			if_id.valid <= 1'b0;
			id_ex.valid <= 1'b0;
			ex_mem.valid <= 1'b0;
			mem_wb.valid <= 1'b0;
		end else begin
			pc <= pc_next;

			// a redirect squashes everything younger than the redirecting stage
			if_id.valid <= !(jump_taken || branch_taken);
			if_id.pc_next <= pc_plus4;
			if_id.instr <= instr;

			id_ex.valid <= if_id.valid && !(jump_taken || branch_taken);
			id_ex.ctrl <= ctrl;
			id_ex.pc_next <= if_id.pc_next;
			id_ex.data_rs <= rdata1;
			id_ex.data_rt <= rdata2;
			id_ex.imm <= id_imm;
			id_ex.pc_jump <= id_pc_jump;
			id_ex.rt <= if_id.instr[20:16];
			id_ex.rd <= if_id.instr[15:11];

			ex_mem.valid <= id_ex.valid && !branch_taken;
			ex_mem.ctrl <= id_ex.ctrl;
			ex_mem.pc_branch <= ex_pc_branch;
			ex_mem.zero <= alu_zero;
			ex_mem.alu_result <= alu_result;
			ex_mem.data_rt <= id_ex.data_rt;
			ex_mem.wreg <= ex_wreg;

			mem_wb.valid <= ex_mem.valid;
			mem_wb.regwrite <= ex_mem.ctrl.regwrite;
			mem_wb.memtoreg <= ex_mem.ctrl.memtoreg;
			mem_wb.memout <= dmem.rdata;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.wreg <= ex_mem.wreg;
		end
	end

endmodule

//--- source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input logic clk,
	input logic rst_n,
	input logic run,
	input logic load_we,
	input logic [cpu_pkg::imem_depth_log2-1:0] load_addr,
	input logic [cpu_pkg::word_w-1:0] load_data,
	input logic [cpu_pkg::reg_addr_w-1:0] dbg_reg,
	output logic [cpu_pkg::word_w-1:0] dbg_data,
	output logic retire_valid,
	output logic [cpu_pkg::reg_addr_w-1:0] retire_reg,
	output logic [cpu_pkg::word_w-1:0] retire_data
);

	logic [cpu_pkg::word_w-1:0] pc;
	logic [cpu_pkg::word_w-1:0] instr;
	logic [5:0] opcode;
	logic [5:0] funct;
	cpu_pkg::ctrl_t ctrl;
	logic [cpu_pkg::reg_addr_w-1:0] rreg1;
	logic [cpu_pkg::reg_addr_w-1:0] rreg2;
	logic [cpu_pkg::word_w-1:0] rdata1;
	logic [cpu_pkg::word_w-1:0] rdata2;
	cpu_pkg::alu_op_t alu_op;
	logic [cpu_pkg::word_w-1:0] alu_s;
	logic [cpu_pkg::word_w-1:0] alu_t;
	logic [4:0] shamt;
	logic [cpu_pkg::word_w-1:0] alu_result;
	logic alu_zero;

	dmem_if dbus ();

	cpu_core core (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.pc(pc),
		.instr(instr),
		.opcode(opcode),
		.funct(funct),
		.ctrl(ctrl),
		.rreg1(rreg1),
		.rreg2(rreg2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.alu_op(alu_op),
		.alu_s(alu_s),
		.alu_t(alu_t),
		.shamt(shamt),
		.alu_result(alu_result),
		.alu_zero(alu_zero),
		.dmem(dbus.core),
		// the write-back port doubles as the retirement trace
		.wb_we(retire_valid),
		.wb_reg(retire_reg),
		.wb_data(retire_data)
	);

	control ctrl_dec (
		.opcode(opcode),
		.funct(funct),
		.ctrl(ctrl)
	);

	alu alu_unit (
		.op(alu_op),
		.s(alu_s),
		.t(alu_t),
		.shamt(shamt),
		.result(alu_result),
		.zero(alu_zero)
	);

	regfile rf (
		.clk(clk),
		.rst_n(rst_n),
		.rreg1(rreg1),
		.rreg2(rreg2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.we(retire_valid),
		.wreg(retire_reg),
		.wdata(retire_data),
		.dbg_reg(dbg_reg),
		.dbg_data(dbg_data)
	);

	instr_mem imem (
		.clk(clk),
		.pc(pc),
		.instr(instr),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data)
	);

	data_mem dmem (
		.clk(clk),
		.bus(dbus.mem)
	);

endmodule

//--- verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

	localparam int num_tests = 7;
	localparam int prog_len = 16;
	localparam int max_checks = 4;
	localparam int run_cycles = 40;
	localparam int imem_words = 2**cpu_pkg::imem_depth_log2;
	// twice the nominal row length, which also covers reset and the initial fill
	localparam int watchdog_ns = num_tests * (prog_len + 45) * 10 * 2;
	localparam logic [31:0] nop = 32'h0000_0000;

	logic clk;
	logic rst_n;
	logic run;
	logic load_we;
	logic [cpu_pkg::imem_depth_log2-1:0] load_addr;
	logic [cpu_pkg::word_w-1:0] load_data;
	logic [cpu_pkg::reg_addr_w-1:0] dbg_reg;
	logic [cpu_pkg::word_w-1:0] dbg_data;
	logic retire_valid;
	logic [cpu_pkg::reg_addr_w-1:0] retire_reg;
	logic [cpu_pkg::word_w-1:0] retire_data;

	// test table, one index per row
	string names [num_tests];
	logic [31:0] progs [num_tests][prog_len];
	int prog_cnt [num_tests];
	int chk_reg [num_tests][max_checks];
	logic [31:0] chk_val [num_tests][max_checks];
	int chk_cnt [num_tests];
	int exp_retired [num_tests];

	// last value seen on the retirement port for each register
	logic [31:0] retired_val [32];

	int errors;
	int failed_tests;

	cpu_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data),
		.dbg_reg(dbg_reg),
		.dbg_data(dbg_data),
		.retire_valid(retire_valid),
		.retire_reg(retire_reg),
		.retire_data(retire_data)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] enc_r(input int rd, input int rs, input int rt,
			input int sa, input logic [5:0] fn);
		return {cpu_pkg::op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input int rt, input int rs,
			input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	// target given as a word index
	function automatic logic [31:0] enc_j(input int word_idx);
		return {cpu_pkg::op_j, 26'(word_idx)};
	endfunction

	task automatic begin_row(input int row, input string name, input int retired);
		names[row] = name;
		exp_retired[row] = retired;
	endtask

	task automatic add_word(input int row, input logic [31:0] word);
		progs[row][prog_cnt[row]] = word;
		prog_cnt[row]++;
	endtask

	task automatic add_check(input int row, input int r, input logic [31:0] value);
		chk_reg[row][chk_cnt[row]] = r;
		chk_val[row][chk_cnt[row]] = value;
		chk_cnt[row]++;
	endtask

	task automatic build_table();
		int row;
		int i;
		for (row = 0; row < num_tests; row++) begin
			prog_cnt[row] = 0;
			chk_cnt[row] = 0;
			for (i = 0; i < prog_len; i++) begin
				progs[row][i] = nop;
			end
		end

		// two nops between producer and consumer
		begin_row(0, "add_sub_slt", 6);
		add_word(0, enc_i(cpu_pkg::op_addi, 1, 0, 12));
		add_word(0, enc_i(cpu_pkg::op_addi, 2, 0, -5));
		add_word(0, nop);
		add_word(0, nop);
		add_word(0, enc_r(3, 1, 2, 0, cpu_pkg::fn_add));
		add_word(0, enc_r(4, 1, 2, 0, cpu_pkg::fn_sub));
		add_word(0, enc_r(5, 2, 1, 0, cpu_pkg::fn_slt));
		add_word(0, enc_r(6, 1, 2, 0, cpu_pkg::fn_slt));
		add_check(0, 3, 32'd7);
		add_check(0, 4, 32'd17);
		add_check(0, 5, 32'd1);
		add_check(0, 6, 32'd0);

		begin_row(1, "and_or_sll", 5);
		add_word(1, enc_i(cpu_pkg::op_addi, 1, 0, 32'h1f0));
		add_word(1, enc_i(cpu_pkg::op_addi, 2, 0, -256));
		add_word(1, nop);
		add_word(1, nop);
		add_word(1, enc_r(3, 1, 2, 0, cpu_pkg::fn_and));
		add_word(1, enc_r(4, 1, 2, 0, cpu_pkg::fn_or));
		add_word(1, enc_r(5, 0, 1, 3, cpu_pkg::fn_sll));
		add_check(1, 2, 32'hffff_ff00);
		add_check(1, 3, 32'h0000_0100);
		add_check(1, 4, 32'hffff_fff0);
		add_check(1, 5, 32'h0000_0f80);

		// the r0 write lands in the same cycle that r10 decodes
		begin_row(2, "addi_r0", 3);
		add_word(2, enc_i(cpu_pkg::op_addi, 9, 0, -1));
		add_word(2, enc_i(cpu_pkg::op_addi, 0, 0, 55));
		add_word(2, nop);
		add_word(2, nop);
		add_word(2, enc_i(cpu_pkg::op_addi, 10, 0, 3));
		add_word(2, enc_i(cpu_pkg::op_addi, 11, 9, -32768));
		add_check(2, 0, 32'h0000_0000);
		add_check(2, 9, 32'hffff_ffff);
		add_check(2, 10, 32'd3);
		add_check(2, 11, 32'hffff_7fff);

		begin_row(3, "sw_lw", 5);
		add_word(3, enc_i(cpu_pkg::op_addi, 12, 0, 32'h1234));
		add_word(3, enc_i(cpu_pkg::op_addi, 13, 0, 40));
		add_word(3, enc_i(cpu_pkg::op_addi, 16, 0, -2));
		add_word(3, nop);
		add_word(3, nop);
		add_word(3, enc_i(cpu_pkg::op_sw, 12, 13, 8));
		add_word(3, enc_i(cpu_pkg::op_sw, 16, 13, -4));
		add_word(3, enc_i(cpu_pkg::op_lw, 14, 13, 8));
		add_word(3, enc_i(cpu_pkg::op_lw, 17, 13, -4));
		add_check(3, 12, 32'h0000_1234);
		add_check(3, 13, 32'd40);
		add_check(3, 14, 32'h0000_1234);
		add_check(3, 17, 32'hffff_fffe);

		// beq at word 5 lands on word 9
		begin_row(4, "beq_taken", 4);
		add_word(4, enc_i(cpu_pkg::op_addi, 18, 0, 7));
		add_word(4, enc_i(cpu_pkg::op_addi, 19, 0, 7));
		add_word(4, enc_i(cpu_pkg::op_addi, 20, 0, 1));
		add_word(4, nop);
		add_word(4, nop);
		add_word(4, enc_i(cpu_pkg::op_beq, 19, 18, 3));
		add_word(4, enc_i(cpu_pkg::op_addi, 20, 0, 99));
		add_word(4, enc_i(cpu_pkg::op_addi, 21, 0, 99));
		add_word(4, enc_i(cpu_pkg::op_addi, 22, 0, 99));
		add_word(4, enc_i(cpu_pkg::op_addi, 23, 0, 5));
		add_check(4, 20, 32'd1);
		add_check(4, 21, 32'd0);
		add_check(4, 22, 32'd0);
		add_check(4, 23, 32'd5);

		begin_row(5, "beq_not_taken", 6);
		add_word(5, enc_i(cpu_pkg::op_addi, 18, 0, 7));
		add_word(5, enc_i(cpu_pkg::op_addi, 19, 0, 8));
		add_word(5, nop);
		add_word(5, nop);
		add_word(5, enc_i(cpu_pkg::op_beq, 19, 18, 3));
		add_word(5, enc_i(cpu_pkg::op_addi, 24, 0, 11));
		add_word(5, enc_i(cpu_pkg::op_addi, 25, 0, 12));
		add_word(5, enc_i(cpu_pkg::op_addi, 26, 0, 13));
		add_word(5, enc_i(cpu_pkg::op_addi, 27, 0, 14));
		add_check(5, 24, 32'd11);
		add_check(5, 25, 32'd12);
		add_check(5, 26, 32'd13);
		add_check(5, 27, 32'd14);

		// words 2 and 3 are squashed, 4 and 5 are jumped over
		begin_row(6, "jump", 2);
		add_word(6, enc_i(cpu_pkg::op_addi, 28, 0, 1));
		add_word(6, enc_j(6));
		add_word(6, enc_i(cpu_pkg::op_addi, 28, 0, 2));
		add_word(6, enc_i(cpu_pkg::op_addi, 29, 0, 3));
		add_word(6, enc_i(cpu_pkg::op_addi, 31, 0, 9));
		add_word(6, enc_i(cpu_pkg::op_addi, 31, 0, 9));
		add_word(6, enc_i(cpu_pkg::op_addi, 30, 0, 4));
		add_check(6, 28, 32'd1);
		add_check(6, 29, 32'd0);
		add_check(6, 30, 32'd4);
		add_check(6, 31, 32'd0);
	endtask

	task automatic write_imem(input int addr, input logic [31:0] word);
		@(posedge clk);
		load_we <= 1'b1;
		load_addr <= addr[cpu_pkg::imem_depth_log2-1:0];
		load_data <= word;
	endtask

	// opcode 6'h3f decodes to a bubble
	task automatic fill_unused();
		int i;
		for (i = prog_len; i < imem_words; i++) begin
			write_imem(i, {6'h3f, 20'($urandom), 6'(i)});
		end
		@(posedge clk);
		load_we <= 1'b0;
	endtask

	task automatic load_program(input int row);
		int i;
		for (i = 0; i < prog_len; i++) begin
			write_imem(i, progs[row][i]);
		end
		@(posedge clk);
		load_we <= 1'b0;
	endtask

	task automatic run_program(output int retired);
		retired = 0;
		@(posedge clk);
		run <= 1'b1;
		repeat (run_cycles) begin
			@(negedge clk);
			if (retire_valid && retire_reg != '0) begin
				retired++;
				retired_val[retire_reg] = retire_data;
			end
		end
		@(posedge clk);
		run <= 1'b0;
	endtask

	task automatic read_reg(input int r, output logic [31:0] value);
		@(posedge clk);
		dbg_reg <= 5'(r);
		@(negedge clk);
		value = dbg_data;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	initial begin
		#(watchdog_ns);
		$display("timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int t;
		int c;
		int retired;
		int errors_before;
		logic [31:0] value;

		void'($urandom(32'h3eeb));
		errors = 0;
		failed_tests = 0;
		clk = 1'b0;
		rst_n = 1'b0;
		run = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		dbg_reg = '0;
		for (c = 0; c < 32; c++) begin
			retired_val[c] = '0;
		end

		build_table();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		fill_unused();

		for (t = 0; t < num_tests; t++) begin
			errors_before = errors;
			load_program(t);
			run_program(retired);
			for (c = 0; c < chk_cnt[t]; c++) begin
				read_reg(chk_reg[t][c], value);
				check_value($sformatf("%s r%0d", names[t], chk_reg[t][c]),
					chk_val[t][c], value);
				// r0 writes are not recorded from the retirement port
				if (chk_reg[t][c] != 0) begin
					check_value($sformatf("%s retired r%0d", names[t], chk_reg[t][c]),
						chk_val[t][c], retired_val[chk_reg[t][c]]);
				end
			end
			check_value($sformatf("%s retirements", names[t]), exp_retired[t], retired);
			if (errors == errors_before) begin
				$display("test %s: ok", names[t]);
			end else begin
				$display("test %s: %0d mismatches", names[t], errors - errors_before);
				failed_tests++;
			end
		end

		$display("tests run %0d, tests failed %0d, checks failed %0d",
			num_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- flist.f
source/cpu_pkg.sv
source/dmem_if.sv
source/control.sv
source/alu.sv
source/regfile.sv
source/instr_mem.sv
source/data_mem.sv
source/cpu_core.sv
source/cpu_top.sv
verification/cpu_tb.sv
